//--- src.f
verilog/bp_pkg.sv
verilog/bank_fetch_steer.sv
verilog/pred_bank.sv
verilog/fetch_pred_select.sv
verilog/branch_pred_top.sv
test/tb_branch_pred.sv

//--- run_sim.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_branch_pred \
    -f src.f

# keep going after a failing run so the log still gets checked
./obj_dir/Vtb_branch_pred > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- test/tb_branch_pred.sv
`timescale 1ns/1ps

module tb_branch_pred;
    import bp_pkg::*;

    // bank bit plus index, i.e. one flat model slot per entry
    localparam int slot_w          = bank_idx_w + 1;
    localparam int model_size      = num_banks * bank_entries;
    localparam int clk_half        = 4;
    localparam int reset_cycles    = 10;
    localparam int settle_limit    = 20;
    localparam int watchdog_cycles = 5000;
    localparam int random_cycles   = 600;

    // small window so updates and lookups keep colliding
    localparam logic [pc_w-1:0] win_base   = 30'h0002_4a00;
    // same index and bank, different tag
    localparam logic [pc_w-1:0] alias_step = pc_w'(model_size);

    logic            clk;
    logic            arst_n;
    logic [pc_w-1:0] pc;
    logic [pc_w-1:0] branch_pc;
    br_type_e        branch_br_type;
    logic [pc_w-1:0] branch_br_target;
    logic            branch_jump;
    logic [pc_w-1:0] pred0_br_target;
    br_type_e        pred0_br_type;
    logic [pc_w-1:0] pred1_br_target;
    br_type_e        pred1_br_type;
    logic [pc_w-1:0] predict_br_target;

    //////////////////////////////
    // reference model
    //////////////////////////////

    logic             m_valid  [model_size];
    logic [tag_w-1:0] m_tag    [model_size];
    br_type_e         m_type   [model_size];
    logic [pc_w-1:0]  m_target [model_size];
    // counter as 0..3, 2 and up means taken
    int               m_ctr    [model_size];

    logic [slot_w-1:0] upd_slot;

    // expected outputs, slot case 1, 2 or 3
    logic [pc_w-1:0] exp_pred0_target;
    br_type_e        exp_pred0_type;
    logic [pc_w-1:0] exp_pred1_target;
    br_type_e        exp_pred1_type;
    logic [pc_w-1:0] exp_next;
    int              exp_case;

    int          error_count = 0;
    int          check_count = 0;
    int          case1_count = 0;
    int          case2_count = 0;
    logic [31:0] rng_state;

    branch_pred_top branch_pred_top_inst (
        .clk               (clk),
        .arst_n            (arst_n),
        .pc                (pc),
        .pred0_br_target   (pred0_br_target),
        .pred0_br_type     (pred0_br_type),
        .pred1_br_target   (pred1_br_target),
        .pred1_br_type     (pred1_br_type),
        .predict_br_target (predict_br_target),
        .branch_pc         (branch_pc),
        .branch_br_type    (branch_br_type),
        .branch_br_target  (branch_br_target),
        .branch_jump       (branch_jump)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    assign upd_slot = branch_pc[slot_w-1:0];

    // written on the same edge as the DUT tables
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < model_size; i++) begin
                m_valid[i] <= 1'b0;
                m_ctr[i]   <= 1;
            end
        end else if (branch_br_type != br_none) begin
            m_valid[upd_slot]  <= 1'b1;
            m_tag[upd_slot]    <= branch_pc[pc_w-1:slot_w];
            m_type[upd_slot]   <= branch_br_type;
            m_target[upd_slot] <= branch_br_target;
            if (branch_br_type != br_cond) begin
                m_ctr[upd_slot] <= 3;
            end else if (branch_jump && m_ctr[upd_slot] < 3) begin
                m_ctr[upd_slot] <= m_ctr[upd_slot] + 1;
            end else if (!branch_jump && m_ctr[upd_slot] > 0) begin
                m_ctr[upd_slot] <= m_ctr[upd_slot] - 1;
            end
        end
    end

    // one slot against the model tables
    function automatic void model_lookup(
        input  logic [pc_w-1:0] a,
        output br_type_e        kind,
        output logic [pc_w-1:0] target,
        output logic            redirect
    );
        logic [slot_w-1:0] k;
        k        = a[slot_w-1:0];
        kind     = br_none;
        target   = '0;
        redirect = 1'b0;
        if (m_valid[k] && m_tag[k] == a[pc_w-1:slot_w]) begin
            kind     = m_type[k];
            target   = m_target[k];
            redirect = (kind == br_jump) || (kind == br_ret) ||
                       (kind == br_cond && m_ctr[k] >= 2);
        end
    endfunction

    always_comb begin
        br_type_e        kind0;
        br_type_e        kind1;
        logic [pc_w-1:0] tgt0;
        logic [pc_w-1:0] tgt1;
        logic            red0;
        logic            red1;
        logic [pc_w-1:0] seq;
        model_lookup(pc, kind0, tgt0, red0);
        model_lookup(pc + pc_w'(1), kind1, tgt1, red1);
        // next aligned pair
        seq = (pc + pc_w'(2)) & ~pc_w'(1);
        exp_pred0_target = seq;
        exp_pred0_type   = br_none;
        exp_pred1_target = '0;
        exp_pred1_type   = br_none;
        exp_next         = seq;
        exp_case         = 3;
        if (red0) begin
            exp_pred0_target = tgt0;
            exp_pred0_type   = kind0;
            exp_next         = tgt0;
            exp_case         = 1;
        end else if (!pc[0] && red1) begin
            // odd pc drops slot 1, it starts the next pair
            exp_pred0_target = '0;
            exp_pred1_target = tgt1;
            exp_pred1_type   = kind1;
            exp_next         = tgt1;
            exp_case         = 2;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic report_mismatch(
        input string           what,
        input logic [pc_w-1:0] got,
        input logic [pc_w-1:0] want
    );
        error_count++;
        $display("error at %0t ns: %s is %h, model gives %h, pc %h", $time, what, got, want, pc);
    endtask

    // negedge, midway between drive points
    pred0_target_a: assert property (@(negedge clk) disable iff (!arst_n)
        pred0_br_target == exp_pred0_target)
        else report_mismatch("pred0_br_target", pred0_br_target, exp_pred0_target);

    pred0_type_a: assert property (@(negedge clk) disable iff (!arst_n)
        pred0_br_type == exp_pred0_type)
        else report_mismatch("pred0_br_type", pc_w'(pred0_br_type), pc_w'(exp_pred0_type));

    pred1_target_a: assert property (@(negedge clk) disable iff (!arst_n)
        pred1_br_target == exp_pred1_target)
        else report_mismatch("pred1_br_target", pred1_br_target, exp_pred1_target);

    pred1_type_a: assert property (@(negedge clk) disable iff (!arst_n)
        pred1_br_type == exp_pred1_type)
        else report_mismatch("pred1_br_type", pc_w'(pred1_br_type), pc_w'(exp_pred1_type));

    next_target_a: assert property (@(negedge clk) disable iff (!arst_n)
        predict_br_target == exp_next)
        else report_mismatch("predict_br_target", predict_br_target, exp_next);

    // how often each select case was hit
    always @(negedge clk) begin
        if (arst_n) begin
            check_count++;
            if (exp_case == 1) begin
                case1_count++;
            end else if (exp_case == 2) begin
                case2_count++;
            end
        end
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // one fetch plus one optional update
    task automatic drive_cycle(
        input logic [pc_w-1:0] fetch_pc,
        input logic [pc_w-1:0] upd_pc,
        input br_type_e        upd_type,
        input logic [pc_w-1:0] upd_target,
        input logic            upd_jump
    );
        @(posedge clk);
        #1;
        pc               = fetch_pc;
        branch_pc        = upd_pc;
        branch_br_type   = upd_type;
        branch_br_target = upd_target;
        branch_jump      = upd_jump;
    endtask

    task automatic drive_lookup(input logic [pc_w-1:0] fetch_pc);
        drive_cycle(fetch_pc, '0, br_none, '0, 1'b0);
    endtask

    task automatic wait_for_sequential(input int limit);
        int n;
        n = 0;
        while (predict_br_target != ((pc + pc_w'(2)) & ~pc_w'(1)) && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (n >= limit) begin
            $display("DUT gave no sequential prediction within %0d cycles of reset", limit);
            error_count++;
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        logic [31:0]     r;
        logic [31:0]     rt;
        logic [pc_w-1:0] fetch;
        logic [pc_w-1:0] upd;
        logic [pc_w-1:0] c;
        br_type_e        kind;
        arst_n           = 1'b0;
        pc               = '0;
        branch_pc        = '0;
        branch_br_type   = br_none;
        branch_br_target = '0;
        branch_jump      = 1'b0;
        rng_state        = 32'h5f29_47a5;
        repeat (reset_cycles) @(posedge clk);
        #1;
        arst_n = 1'b1;
        wait_for_sequential(settle_limit);

        // empty tables, sequential everywhere, incl. the top of memory
        for (int i = 0; i < 12; i++) begin
            drive_lookup(win_base + pc_w'(i));
        end
        drive_lookup('1);
        drive_lookup('1 - pc_w'(1));

        // jump at an even slot, written while it is looked up
        drive_cycle(win_base + pc_w'(4), win_base + pc_w'(4), br_jump, 30'h0001_0040, 1'b0);
        drive_lookup(win_base + pc_w'(4));
        // odd pc, taken jump at pc+1 must be ignored
        drive_lookup(win_base + pc_w'(3));
        // return at an odd slot, seen from slot 1 of the even pc
        drive_cycle(win_base, win_base + pc_w'(9), br_ret, 30'h0003_3330, 1'b0);
        drive_lookup(win_base + pc_w'(9));
        drive_lookup(win_base + pc_w'(8));

        // conditional counter walk, up, down, both rails
        c = win_base + pc_w'(12);
        drive_cycle(c, c, br_cond, 30'h0000_7700, 1'b1);
        drive_lookup(c);
        repeat (2) drive_cycle(c, c, br_cond, 30'h0000_7700, 1'b0);
        drive_lookup(c);
        repeat (3) drive_cycle(c, c, br_cond, 30'h0000_7700, 1'b0);
        repeat (5) drive_cycle(c, c, br_cond, 30'h0000_7700, 1'b1);
        drive_cycle(c, c, br_cond, 30'h0000_7700, 1'b0);
        drive_lookup(c);

        // alias shares the index but not the tag
        drive_lookup(win_base + pc_w'(4) + alias_step);
        drive_cycle(win_base, win_base + pc_w'(4) + alias_step, br_jump, 30'h0005_5550, 1'b0);
        drive_lookup(win_base + pc_w'(4));
        drive_lookup(win_base + pc_w'(4) + alias_step);

        // random mix over the window
        for (int i = 0; i < random_cycles; i++) begin
            draw(r);
            draw(rt);
            fetch = win_base + pc_w'(r[3:0]);
            upd   = win_base + pc_w'(r[7:4]);
            if (r[8]) begin
                upd = upd + alias_step;
            end
            kind = r[10] ? br_type_e'(r[12:11]) : br_none;
            drive_cycle(fetch, upd, kind, rt[pc_w-1:0], r[13]);
        end
        drive_lookup(win_base);
        @(posedge clk);

        if (case1_count == 0) begin
            $display("stimulus never produced a slot 0 redirect");
            error_count++;
        end
        if (case2_count == 0) begin
            $display("stimulus never produced a slot 1 redirect");
            error_count++;
        end
        $display("checks %0d, slot 0 redirects %0d, slot 1 redirects %0d, errors %0d",
                 check_count, case1_count, case2_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // hang guard
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < watchdog_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("simulation did not finish within %0d cycles", watchdog_cycles);
        $display("Something failed");
        $finish;
    end

endmodule

//--- verilog/branch_pred_top.sv
`timescale 1ns/1ps

module branch_pred_top (
    input  logic                    clk,
    input  logic                    arst_n,
    // prediction side
    input  logic [bp_pkg::pc_w-1:0] pc,
    output logic [bp_pkg::pc_w-1:0] pred0_br_target,
    output bp_pkg::br_type_e        pred0_br_type,
    output logic [bp_pkg::pc_w-1:0] pred1_br_target,
    output bp_pkg::br_type_e        pred1_br_type,
    output logic [bp_pkg::pc_w-1:0] predict_br_target,
    // resolved branch from the branch unit
    input  logic [bp_pkg::pc_w-1:0] branch_pc,
    input  bp_pkg::br_type_e        branch_br_type,
    input  logic [bp_pkg::pc_w-1:0] branch_br_target,
    // resolved direction, drives the counters
    input  logic                    branch_jump
);
    import bp_pkg::*;

    //////////////////////////////
    // internal wires
    //////////////////////////////

    // steer to banks
    logic [pc_w-1:0]      bank_pc     [num_banks];
    logic                 first_bank;

    // banks to select
    logic [pc_w-1:0]      bank_target [num_banks];
    br_type_e             bank_type   [num_banks];
    logic [num_banks-1:0] bank_taken;

    //////////////////////////////
    // steer
    //////////////////////////////

    bank_fetch_steer steer_inst (
        .pc         (pc),
        .bank_pc    (bank_pc),
        .first_bank (first_bank)
    );

    //////////////////////////////
    // banks
    //////////////////////////////

    // even bank at 0, odd bank at 1
    // both see the update, parity decides who writes
    for (genvar gi = 0; gi < num_banks; gi++) begin : bank_gen
        pred_bank #(
            .bank_id (gi)
        ) pred_bank_inst (
            .clk           (clk),
            .arst_n        (arst_n),
            .lookup_pc     (bank_pc[gi]),
            .hit_target    (bank_target[gi]),
            .hit_type      (bank_type[gi]),
            .taken         (bank_taken[gi]),
            .update_pc     (branch_pc),
            .update_type   (branch_br_type),
            .update_target (branch_br_target),
            .update_jump   (branch_jump)
        );
    end

    //////////////////////////////
    // select
    //////////////////////////////

    fetch_pred_select select_inst (
        .pc                (pc),
        .first_bank        (first_bank),
        .bank_target       (bank_target),
        .bank_type         (bank_type),
        .bank_taken        (bank_taken),
        .pred0_br_target   (pred0_br_target),
        .pred0_br_type     (pred0_br_type),
        .pred1_br_target   (pred1_br_target),
        .pred1_br_type     (pred1_br_type),
        .predict_br_target (predict_br_target)
    );

endmodule

//--- verilog/fetch_pred_select.sv
`timescale 1ns/1ps

module fetch_pred_select (
    // fetch pc, slot 0
    input  logic [bp_pkg::pc_w-1:0] pc,
    // bank holding slot 0
    input  logic                    first_bank,
    // per bank lookup results
    input  logic [bp_pkg::pc_w-1:0] bank_target [bp_pkg::num_banks],
    input  bp_pkg::br_type_e        bank_type   [bp_pkg::num_banks],
    input  logic [bp_pkg::num_banks-1:0] bank_taken,
    // per slot predictions
    output logic [bp_pkg::pc_w-1:0] pred0_br_target,
    output bp_pkg::br_type_e        pred0_br_type,
    output logic [bp_pkg::pc_w-1:0] pred1_br_target,
    output bp_pkg::br_type_e        pred1_br_type,
    // next fetch address
    output logic [bp_pkg::pc_w-1:0] predict_br_target
);
    import bp_pkg::*;

    logic [pc_w-1:0] pc_plus_2;
    logic [pc_w-1:0] fall_through;
    logic            second_bank;
    logic            slot0_taken;
    logic            slot1_taken;

    //////////////////////////////
    // slot ordering
    //////////////////////////////

    assign second_bank = ~first_bank;
    assign slot0_taken = bank_taken[first_bank];

    // slot 1 only counts inside an aligned pair
    assign slot1_taken = bank_taken[second_bank] & ~pc[0];

    // next aligned pair
    assign pc_plus_2    = pc + pc_w'(2);
    assign fall_through = {pc_plus_2[pc_w-1:1], 1'b0};

    //////////////////////////////
    // three way select
    //////////////////////////////

    always_comb begin
        // default is the sequential case
        pred0_br_target   = fall_through;
        pred0_br_type     = br_none;
        pred1_br_target   = '0;
        pred1_br_type     = br_none;
        predict_br_target = fall_through;
        if (slot0_taken) begin
            // first slot wins, second is shadowed
            pred0_br_target   = bank_target[first_bank];
            pred0_br_type     = bank_type[first_bank];
            predict_br_target = bank_target[first_bank];
        end else if (slot1_taken) begin
            // redirect from the second slot
            pred0_br_target   = '0;
            pred1_br_target   = bank_target[second_bank];
            pred1_br_type     = bank_type[second_bank];
            predict_br_target = bank_target[second_bank];
        end
    end

endmodule

//--- verilog/pred_bank.sv
`timescale 1ns/1ps

module pred_bank #(
    // parity of the word addresses this bank serves
    parameter int bank_id = 0
) (
    input  logic                    clk,
    input  logic                    arst_n,
    // lookup side
    input  logic [bp_pkg::pc_w-1:0] lookup_pc,
    output logic [bp_pkg::pc_w-1:0] hit_target,
    output bp_pkg::br_type_e        hit_type,
    output logic                    taken,
    // update side, straight from the branch unit
    input  logic [bp_pkg::pc_w-1:0] update_pc,
    input  bp_pkg::br_type_e        update_type,
    input  logic [bp_pkg::pc_w-1:0] update_target,
    input  logic                    update_jump
);
    import bp_pkg::*;

    //////////////////////////////
    // storage
    //////////////////////////////

    // btb entry fields
    logic                  valid_q  [bank_entries];
    logic [tag_w-1:0]      tag_q    [bank_entries];
    br_type_e              type_q   [bank_entries];
    logic [pc_w-1:0]       target_q [bank_entries];

    // direction counters
    pht_state_e            pht_q    [bank_entries];

    // lookup decode
    logic [bank_idx_w-1:0] lk_idx;
    logic [tag_w-1:0]      lk_tag;
    logic                  lk_hit;

    // update decode
    logic [bank_idx_w-1:0] up_idx;
    logic [tag_w-1:0]      up_tag;
    logic                  up_en;

    // next counter value for one resolved branch
    function automatic pht_state_e pht_next(
        input pht_state_e cur,
        input br_type_e   kind,
        input logic       jump
    );
        pht_state_e nxt;
        nxt = cur;
        if (kind == br_cond) begin
            if (jump) begin
                // count up, stick at strong taken
                case (cur)
                    pht_strong_nt: nxt = pht_weak_nt;
                    pht_weak_nt:   nxt = pht_weak_t;
                    pht_weak_t:    nxt = pht_strong_t;
                    default:       nxt = pht_strong_t;
                endcase
            end else begin
                // count down, stick at strong not taken
                case (cur)
                    pht_strong_t:  nxt = pht_weak_t;
                    pht_weak_t:    nxt = pht_weak_nt;
                    pht_weak_nt:   nxt = pht_strong_nt;
                    default:       nxt = pht_strong_nt;
                endcase
            end
        end else if (kind == br_jump || kind == br_ret) begin
            // unconditional, always taken
            nxt = pht_strong_t;
        end
        return nxt;
    endfunction

    //////////////////////////////
    // lookup
    //////////////////////////////

    // bit 0 is implied by the bank
    assign lk_idx = lookup_pc[bank_idx_w:1];
    assign lk_tag = lookup_pc[pc_w-1:bank_idx_w+1];
    assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

    // combinational read, sees state before this edge's write
    always_comb begin
        hit_target = '0;
        hit_type   = br_none;
        taken      = 1'b0;
        if (lk_hit) begin
            hit_target = target_q[lk_idx];
            hit_type   = type_q[lk_idx];
            case (type_q[lk_idx])
                br_jump, br_ret: taken = 1'b1;
                // msb of the counter
                br_cond:         taken = pht_q[lk_idx][1];
                default:         taken = 1'b0;
            endcase
        end
    end

    //////////////////////////////
    // update
    //////////////////////////////

    assign up_idx = update_pc[bank_idx_w:1];
    assign up_tag = update_pc[pc_w-1:bank_idx_w+1];

    // only the bank matching the branch parity writes
    assign up_en = (update_type != br_none) && (update_pc[0] == bank_id[0]);

    // control state, cleared on reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < bank_entries; i++) begin
                valid_q[i] <= 1'b0;
                pht_q[i]   <= pht_weak_nt;
            end
        end else if (up_en) begin
            valid_q[up_idx] <= 1'b1;
            pht_q[up_idx]   <= pht_next(pht_q[up_idx], update_type, update_jump);
        end
    end

    // payload, qualified by valid
    always_ff @(posedge clk) begin
        if (up_en) begin
            tag_q[up_idx]    <= up_tag;
            type_q[up_idx]   <= update_type;
            target_q[up_idx] <= update_target;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // steering must hand this bank its own parity only
    steer_parity_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        lookup_pc[0] == bank_id[0]
    ) else $error("bank %0d got lookup pc of wrong parity", bank_id);

    // a valid entry always holds a real branch type
    valid_type_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        valid_q[lk_idx] |-> (type_q[lk_idx] != br_none)
    ) else $error("bank %0d holds a valid entry without a branch type", bank_id);

endmodule

//--- verilog/bank_fetch_steer.sv
`timescale 1ns/1ps

module bank_fetch_steer (
    // fetch pc, slot 0 of the pair
    input  logic [bp_pkg::pc_w-1:0] pc,
    // lookup address per bank, even bank first
    output logic [bp_pkg::pc_w-1:0] bank_pc [bp_pkg::num_banks],
    // bank that holds slot pc
    output logic                    first_bank
);
    import bp_pkg::*;

    // companion address for slot 1
    logic [pc_w-1:0] pc_plus_1;

    assign pc_plus_1 = pc + pc_w'(1);

    //////////////////////////////
    // bank routing
    //////////////////////////////

    // pc and pc+1 always differ in bit 0
    // so each bank gets exactly one of them
    always_comb begin
        for (int b = 0; b < num_banks; b++) begin
            // bank parity matches pc -> it sees slot 0
            if (pc[0] == b[0]) begin
                bank_pc[b] = pc;
            end else begin
                bank_pc[b] = pc_plus_1;
            end
        end
    end

    // slot 0 lives in the bank named by its own parity
    assign first_bank = pc[0];

    // note: pc+1 on an odd pc crosses into the next fetch pair,
    // the select block drops that slot, the lookup is still made

endmodule

//--- verilog/bp_pkg.sv
package bp_pkg;

    //////////////////////////////
    // widths and table sizes
    //////////////////////////////

    // word address width, byte offset already stripped
    localparam int pc_w = 30;

    // one bank per word address parity
    localparam int num_banks = 2;

    // index is pc[8:1], bit 0 picks the bank
    localparam int bank_idx_w = 8;
    localparam int bank_entries = 1 << bank_idx_w;

    // whatever is left above the index
    localparam int tag_w = pc_w - bank_idx_w - 1;

    //////////////////////////////
    // encodings
    //////////////////////////////

    // branch kind as reported by the branch unit
    typedef enum logic [1:0] {
        br_none = 2'b00,
        br_cond = 2'b01,
        br_jump = 2'b10,
        br_ret  = 2'b11
    } br_type_e;

    // two bit saturating counter, msb set means taken
    typedef enum logic [1:0] {
        pht_strong_nt = 2'b00,
        pht_weak_nt   = 2'b01,
        pht_weak_t    = 2'b10,
        pht_strong_t  = 2'b11
    } pht_state_e;

endpackage
